// ==== design/rv32i_pkg.sv ====
/* rv32i_pkg
   Shared widths, major opcodes, ALU operation codes and the instruction
   word views for the four stage RV32I integer pipeline. */

package rv32i_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and reset vector
  //////////////////////////////////////////////////////////////////////
  localparam int XLEN       = 32;                   // data and address width
  localparam int REG_ADDR_W = 5;                    // x0..x31

  localparam logic [XLEN-1:0] PC_RESET = '0;        // first fetch after reset
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;     // sequential fetch / link offset

  //////////////////////////////////////////////////////////////////////
  // major opcodes kept by this core
  //////////////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;   // register-register alu
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // register-immediate alu
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // beq..bgeu

  // alu operations, one per OP/OP-IMM function
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // instruction word, seen as R format or as I format
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0]            funct7;                  // also imm high bits of S/B/J
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;                      // imm low bits of B
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;                     // sign extended in decode
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;                                      // register fields, U/B/J imm pieces
    i_fmt_t i;                                      // 12 bit immediate
  } instr_u;

endpackage

// ==== design/rv32i_stage_if.sv ====
/* Stage-to-stage bundles of the pipeline.
   fetch_decode_if carries the acked instruction word, decode_execute_if
   the decoded and registered operation with its operands. */

`timescale 1ns/100ps

interface fetch_decode_if;
  logic                       valid;                // word acked last cycle
  logic [rv32i_pkg::XLEN-1:0] pc;
  rv32i_pkg::instr_u          instr;

  modport source (output valid, pc, instr);
  modport sink   (input  valid, pc, instr);
endinterface

interface decode_execute_if;
  logic                             valid;
  logic [rv32i_pkg::XLEN-1:0]       pc;
  rv32i_pkg::alu_op_e               alu_op;
  logic [rv32i_pkg::REG_ADDR_W-1:0] rs1_addr;       // kept for forwarding compare
  logic [rv32i_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv32i_pkg::XLEN-1:0]       rs1_data;
  logic [rv32i_pkg::XLEN-1:0]       rs2_data;
  logic [rv32i_pkg::XLEN-1:0]       imm;
  logic                             a_sel_pc;       // operand a is the pc
  logic                             b_sel_imm;      // operand b is the immediate
  logic [rv32i_pkg::REG_ADDR_W-1:0] rd_addr;
  logic                             rd_we;
  logic                             is_branch;
  logic                             is_jal;
  logic                             is_jalr;
  logic [2:0]                       funct3;         // branch condition

  modport source (output valid, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data, imm,
                         a_sel_pc, b_sel_imm, rd_addr, rd_we, is_branch, is_jal, is_jalr,
                         funct3);
  modport sink   (input  valid, pc, alu_op, rs1_addr, rs2_addr, rs1_data, rs2_data, imm,
                         a_sel_pc, b_sel_imm, rd_addr, rd_we, is_branch, is_jal, is_jalr,
                         funct3);
endinterface

// ==== design/rv32i_fetch.sv ====
/* Instruction fetch stage.
   Holds the PC, keeps one strobe/ack request to instruction memory
   outstanding and drops a response that a redirect has made stale. */

`timescale 1ns/100ps

module rv32i_fetch (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_imem_ack,
  input  logic [rv32i_pkg::XLEN-1:0] i_imem_instr,
  input  logic                       i_redirect_valid,
  input  logic [rv32i_pkg::XLEN-1:0] i_redirect_pc,
  output logic                       o_imem_stb,
  output logic [rv32i_pkg::XLEN-1:0] o_imem_addr,
  fetch_decode_if.source             fd
);

  logic                       req_q;                // request outstanding
  logic                       discard_q;            // in-flight response is stale
  logic [rv32i_pkg::XLEN-1:0] pc_q;                 // address of current request
  logic [rv32i_pkg::XLEN-1:0] target_q;             // parked redirect target
  logic [rv32i_pkg::XLEN-1:0] pc_next;
  logic                       ack_ok;

  assign ack_ok      = req_q && i_imem_ack;         // ack only counts for a live strobe
  assign o_imem_stb  = req_q;
  assign o_imem_addr = pc_q;                        // held until ack

  // redirect in the ack cycle wins, else a parked target, else sequential
  always_comb begin
    if (i_redirect_valid) begin
      pc_next = i_redirect_pc;
    end else if (discard_q) begin
      pc_next = target_q;
    end else begin
      pc_next = pc_q + rv32i_pkg::PC_STEP;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      req_q     <= 1'b0;
      discard_q <= 1'b0;
      pc_q      <= rv32i_pkg::PC_RESET;
    end else begin
      req_q <= 1'b1;                                // next request right after the ack
      if (ack_ok) begin
        pc_q      <= pc_next;
        discard_q <= 1'b0;                          // stale word has arrived
      end else if (i_redirect_valid) begin
        discard_q <= req_q;                         // old-path word still in flight
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_redirect_valid && !ack_ok) begin
      target_q <= i_redirect_pc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // hand the acked word to decode one cycle later
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fd.valid <= 1'b0;
    end else begin
      fd.valid <= ack_ok && !discard_q && !i_redirect_valid;  // squash old path
    end
  end

  always_ff @(posedge i_clk) begin
    if (ack_ok) begin
      fd.pc    <= pc_q;
      fd.instr <= i_imem_instr;
    end
  end

endmodule

// ==== design/rv32i_decode.sv ====
/* Decode stage.
   Splits the fetched word into ALU operation, operand selects, immediate
   and control flags, reads the register file and registers the result. */

`timescale 1ns/100ps

module rv32i_decode (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic                             i_redirect_valid,
  fetch_decode_if.sink                     fd,
  output logic [rv32i_pkg::REG_ADDR_W-1:0] o_rs1_addr,
  output logic [rv32i_pkg::REG_ADDR_W-1:0] o_rs2_addr,
  input  logic [rv32i_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [rv32i_pkg::XLEN-1:0]       i_rs2_data,
  decode_execute_if.source                 de
);

  rv32i_pkg::instr_u          ins;
  rv32i_pkg::alu_op_e         arith_op;             // op from funct3/funct7
  rv32i_pkg::alu_op_e         alu_op;
  logic [rv32i_pkg::XLEN-1:0] imm_i, imm_u, imm_b, imm_j;
  logic [rv32i_pkg::XLEN-1:0] imm;
  logic                       alt;                  // sub / sra select
  logic                       a_sel_pc, b_sel_imm, rd_we;
  logic                       is_branch, is_jal, is_jalr;

  assign ins = fd.instr;

  // immediates, U/B/J pieced together from the R view
  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_u = {ins.r.funct7, ins.r.rs2, ins.r.rs1, ins.r.funct3, 12'b0};
  assign imm_b = {{20{ins.r.funct7[6]}}, ins.r.rd[0], ins.r.funct7[5:0], ins.r.rd[4:1], 1'b0};
  assign imm_j = {{12{ins.r.funct7[6]}}, ins.r.rs1, ins.r.funct3, ins.r.rs2[0],
                  ins.r.funct7[5:0], ins.r.rs2[4:1], 1'b0};

  // lui reads x0 so the alu adds the immediate to zero
  assign o_rs1_addr = (ins.r.opcode == rv32i_pkg::OPC_LUI) ? '0 : ins.r.rs1;
  assign o_rs2_addr = ins.r.rs2;

  // OP-IMM honours funct7 bit 5 only on shifts
  assign alt = ins.r.funct7[5] &&
               (ins.r.opcode == rv32i_pkg::OPC_OP || ins.r.funct3 == 3'b101);

  always_comb begin
    case (ins.r.funct3)
      3'b000:  arith_op = alt ? rv32i_pkg::ALU_SUB : rv32i_pkg::ALU_ADD;
      3'b001:  arith_op = rv32i_pkg::ALU_SLL;
      3'b010:  arith_op = rv32i_pkg::ALU_SLT;
      3'b011:  arith_op = rv32i_pkg::ALU_SLTU;
      3'b100:  arith_op = rv32i_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
      3'b110:  arith_op = rv32i_pkg::ALU_OR;
      default: arith_op = rv32i_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    alu_op    = rv32i_pkg::ALU_ADD;                 // defaults give a no-op
    imm       = imm_i;
    a_sel_pc  = 1'b0;
    b_sel_imm = 1'b1;
    rd_we     = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    case (ins.r.opcode)
      rv32i_pkg::OPC_OP: begin
        alu_op    = arith_op;
        b_sel_imm = 1'b0;
        rd_we     = 1'b1;
      end
      rv32i_pkg::OPC_OP_IMM: begin
        alu_op = arith_op;                          // shamt sits in imm[4:0]
        rd_we  = 1'b1;
      end
      rv32i_pkg::OPC_LUI: begin
        imm   = imm_u;
        rd_we = 1'b1;
      end
      rv32i_pkg::OPC_AUIPC: begin
        imm      = imm_u;
        a_sel_pc = 1'b1;
        rd_we    = 1'b1;
      end
      rv32i_pkg::OPC_JAL: begin
        imm    = imm_j;
        rd_we  = 1'b1;
        is_jal = 1'b1;
      end
      rv32i_pkg::OPC_JALR: begin
        rd_we   = 1'b1;
        is_jalr = 1'b1;
      end
      rv32i_pkg::OPC_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      default: ;                                    // unknown opcode retires without write
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // decode pipeline register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= fd.valid && !i_redirect_valid;    // younger than a taken branch
    end
  end

  always_ff @(posedge i_clk) begin
    de.pc        <= fd.pc;
    de.alu_op    <= alu_op;
    de.rs1_addr  <= o_rs1_addr;
    de.rs2_addr  <= o_rs2_addr;
    de.rs1_data  <= i_rs1_data;
    de.rs2_data  <= i_rs2_data;
    de.imm       <= imm;
    de.a_sel_pc  <= a_sel_pc;
    de.b_sel_imm <= b_sel_imm;
    de.rd_addr   <= ins.r.rd;
    de.rd_we     <= rd_we;
    de.is_branch <= is_branch;
    de.is_jal    <= is_jal;
    de.is_jalr   <= is_jalr;
    de.funct3    <= ins.r.funct3;
  end

endmodule

// ==== design/rv32i_regfile.sv ====
/* Integer register file.
   31 general registers, x0 hardwired to zero, two combinational reads
   for decode and one write from writeback passed through same cycle. */

`timescale 1ns/100ps

module rv32i_regfile (
  input  logic                             i_clk,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  input  logic                             i_we,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic [rv32i_pkg::XLEN-1:0]       i_rd_data,
  output logic [rv32i_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv32i_pkg::XLEN-1:0]       o_rs2_data
);

  logic [rv32i_pkg::XLEN-1:0] regs [1:31];          // no storage for x0

  // x0, then write-through, then stored value
  function automatic logic [rv32i_pkg::XLEN-1:0] read_port(
    input logic [rv32i_pkg::REG_ADDR_W-1:0] addr
  );
    logic [rv32i_pkg::XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (i_we && addr == i_rd_addr) begin
      data = i_rd_data;                             // retiring write seen by decode
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1_addr);
    o_rs2_data = read_port(i_rs2_addr);
  end

  always_ff @(posedge i_clk) begin
    if (i_we && i_rd_addr != '0) begin              // writes to x0 dropped
      regs[i_rd_addr] <= i_rd_data;
    end
  end

endmodule

// ==== design/rv32i_execute.sv ====
/* Execute stage with writeback register.
   Forwards from writeback, runs the ALU, resolves branches and jumps
   into a one-cycle redirect and registers the retiring result. */

`timescale 1ns/100ps

module rv32i_execute (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  decode_execute_if.sink                   de,
  output logic                             o_redirect_valid,
  output logic [rv32i_pkg::XLEN-1:0]       o_redirect_pc,
  output logic                             o_wb_valid,
  output logic                             o_wb_we,
  output logic [rv32i_pkg::REG_ADDR_W-1:0] o_wb_rd_addr,
  output logic [rv32i_pkg::XLEN-1:0]       o_wb_rd_data,
  output logic [rv32i_pkg::XLEN-1:0]       o_wb_pc
);

  logic [rv32i_pkg::XLEN-1:0] rs1_val, rs2_val;     // after forwarding
  logic [rv32i_pkg::XLEN-1:0] op_a, op_b;
  logic [rv32i_pkg::XLEN-1:0] alu_res;
  logic [rv32i_pkg::XLEN-1:0] link;
  logic [rv32i_pkg::XLEN-1:0] jalr_sum;
  logic                       cond;                 // branch condition holds
  logic                       is_jump;

  //////////////////////////////////////////////////////////////////////
  // forwarding from writeback, o_wb_we already implies valid
  //////////////////////////////////////////////////////////////////////
  assign rs1_val = (o_wb_we && o_wb_rd_addr != '0 && o_wb_rd_addr == de.rs1_addr) ?
                   o_wb_rd_data : de.rs1_data;
  assign rs2_val = (o_wb_we && o_wb_rd_addr != '0 && o_wb_rd_addr == de.rs2_addr) ?
                   o_wb_rd_data : de.rs2_data;

  assign op_a = de.a_sel_pc  ? de.pc  : rs1_val;    // auipc
  assign op_b = de.b_sel_imm ? de.imm : rs2_val;

  always_comb begin
    case (de.alu_op)
      rv32i_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv32i_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
      rv32i_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      rv32i_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv32i_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
      rv32i_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      rv32i_pkg::ALU_OR:   alu_res = op_a | op_b;
      rv32i_pkg::ALU_AND:  alu_res = op_a & op_b;
      default:             alu_res = op_a + op_b;   // add, lui, auipc
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // branch and jump resolution
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (de.funct3)
      3'b000:  cond = rs1_val == rs2_val;           // beq
      3'b001:  cond = rs1_val != rs2_val;           // bne
      3'b100:  cond = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  cond = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  cond = rs1_val < rs2_val;            // bltu
      3'b111:  cond = rs1_val >= rs2_val;           // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign is_jump  = de.is_jal || de.is_jalr;
  assign link     = de.pc + rv32i_pkg::PC_STEP;
  assign jalr_sum = rs1_val + de.imm;

  assign o_redirect_valid = de.valid && (is_jump || (de.is_branch && cond));
  assign o_redirect_pc    = de.is_jalr ? {jalr_sum[rv32i_pkg::XLEN-1:1], 1'b0} :
                                         de.pc + de.imm;

  //////////////////////////////////////////////////////////////////////
  // writeback register, drives regfile, forwarding and retire port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_valid   <= 1'b0;
      o_wb_we      <= 1'b0;
      o_wb_rd_addr <= '0;
      o_wb_rd_data <= '0;
      o_wb_pc      <= '0;
    end else begin
      o_wb_valid   <= de.valid;
      o_wb_we      <= de.valid && de.rd_we;         // branches and no-ops have we low
      o_wb_rd_addr <= de.rd_addr;
      o_wb_rd_data <= is_jump ? link : alu_res;
      o_wb_pc      <= de.pc;
    end
  end

endmodule

// ==== design/rv32i_core.sv ====
/* RV32I core top level.
   Fetch, decode with register file, and execute with writeback wired
   into a four stage pipeline with a retire port on writeback. */

`timescale 1ns/100ps

module rv32i_core (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  // instruction memory, strobe/ack
  input  logic                             i_imem_ack,
  input  logic [rv32i_pkg::XLEN-1:0]       i_imem_instr,
  output logic                             o_imem_stb,
  output logic [rv32i_pkg::XLEN-1:0]       o_imem_addr,
  // retire port, the writeback register
  output logic                             o_retire_valid,
  output logic                             o_retire_we,
  output logic [rv32i_pkg::REG_ADDR_W-1:0] o_retire_rd_addr,
  output logic [rv32i_pkg::XLEN-1:0]       o_retire_rd_data,
  output logic [rv32i_pkg::XLEN-1:0]       o_retire_pc
);

  logic [rv32i_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [rv32i_pkg::XLEN-1:0]       rs1_data, rs2_data;
  logic                             redirect_valid;   // taken branch or jump
  logic [rv32i_pkg::XLEN-1:0]       redirect_pc;
  logic                             wb_valid, wb_we;
  logic [rv32i_pkg::REG_ADDR_W-1:0] wb_rd_addr;
  logic [rv32i_pkg::XLEN-1:0]       wb_rd_data, wb_pc;

  fetch_decode_if   fd_if ();
  decode_execute_if de_if ();

  assign o_retire_valid   = wb_valid;
  assign o_retire_we      = wb_we;
  assign o_retire_rd_addr = wb_rd_addr;
  assign o_retire_rd_data = wb_rd_data;
  assign o_retire_pc      = wb_pc;

  rv32i_fetch u_fetch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_imem_ack       (i_imem_ack),
    .i_imem_instr     (i_imem_instr),
    .i_redirect_valid (redirect_valid),
    .i_redirect_pc    (redirect_pc),
    .o_imem_stb       (o_imem_stb),
    .o_imem_addr      (o_imem_addr),
    .fd               (fd_if)
  );

  rv32i_decode u_decode (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_redirect_valid (redirect_valid),
    .fd               (fd_if),
    .o_rs1_addr       (rs1_addr),
    .o_rs2_addr       (rs2_addr),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .de               (de_if)
  );

  rv32i_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_we       (wb_we),                          // written from writeback
    .i_rd_addr  (wb_rd_addr),
    .i_rd_data  (wb_rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv32i_execute u_execute (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .de               (de_if),
    .o_redirect_valid (redirect_valid),
    .o_redirect_pc    (redirect_pc),
    .o_wb_valid       (wb_valid),
    .o_wb_we          (wb_we),
    .o_wb_rd_addr     (wb_rd_addr),
    .o_wb_rd_data     (wb_rd_data),
    .o_wb_pc          (wb_pc)
  );

endmodule

// ==== verification/tb_core.sv ====
/* Testbench for the RV32I core.
   Loads programs and expected retire traces from the case file, models
   instruction memory with random or fixed ack delays, checks retires. */

`timescale 1ns/100ps

module tb_core;

  localparam int    CLK_PERIOD     = 40;
  localparam int    RESET_CYCLES   = 16;
  localparam int    LCG_SEED       = 69457;
  localparam int    STB_TIMEOUT    = 8;             // cycles to first strobe
  localparam int    RETIRE_TIMEOUT = 40;            // cycles between retires
  localparam int    MAX_TESTS      = 8;
  localparam int    MAX_ITEMS      = 128;
  localparam int    MEM_WORDS      = 64;            // 256 bytes of program space
  localparam string CASE_FILE      = "verification/core_cases.txt";
  localparam logic [31:0] RESET_PC = 32'h0000_0000; // first fetch address after reset

  logic        clk;
  logic        rst_n      = 1'b0;
  logic        imem_ack   = 1'b0;
  logic [31:0] imem_instr = '0;
  logic        imem_stb;
  logic [31:0] imem_addr;
  logic        retire_valid, retire_we;
  logic [4:0]  retire_rd_addr;
  logic [31:0] retire_rd_data, retire_pc;

  ////////////////////////////////////////////////////////////////////
  // case data and memory model state
  ////////////////////////////////////////////////////////////////////
  logic [8*32-1:0] test_name  [0:MAX_TESTS-1];
  int              prog_first [0:MAX_TESTS];      // entry n+1 closes test n
  int              exp_first  [0:MAX_TESTS];
  logic [31:0]     prog_addr  [0:MAX_ITEMS-1];
  logic [31:0]     prog_word  [0:MAX_ITEMS-1];
  logic [31:0]     exp_pc     [0:MAX_ITEMS-1];
  logic            exp_we     [0:MAX_ITEMS-1];
  logic [4:0]      exp_rd     [0:MAX_ITEMS-1];
  logic [31:0]     exp_data   [0:MAX_ITEMS-1];
  logic [31:0]     mem        [0:MEM_WORDS-1];
  int              n_tests;
  int              errors;
  int              runs_ok, runs_bad;
  logic [31:0]     lcg_state  = LCG_SEED;
  logic            random_acks = 1'b0;
  logic            ack_busy    = 1'b0;
  int              ack_cnt;
  int              ack_delay;

  rv32i_core i_rv32i_core (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_imem_ack       (imem_ack),
    .i_imem_instr     (imem_instr),
    .o_imem_stb       (imem_stb),
    .o_imem_addr      (imem_addr),
    .o_retire_valid   (retire_valid),
    .o_retire_we      (retire_we),
    .o_retire_rd_addr (retire_rd_addr),
    .o_retire_rd_data (retire_rd_data),
    .o_retire_pc      (retire_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // unloaded words carry opcode 0 and run as no-ops
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'b0000000};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (addr < MEM_WORDS*4) begin
      return mem[addr[7:2]];
    end
    return fill_word(addr);
  endfunction

  function int draw_delay();                        // 1..4 cycles
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return 1 + int'(lcg_state[17:16]);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // instruction memory model with one ack per strobe after 1..4 cycles
  ////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      imem_ack <= 1'b0;
      ack_busy <= 1'b0;
    end else if (imem_ack) begin
      imem_ack <= 1'b0;                             // next request starts after ack
    end else if (imem_stb && !ack_busy) begin
      ack_delay = random_acks ? draw_delay() : 1;
      if (ack_delay == 1) begin
        imem_ack   <= 1'b1;
        imem_instr <= read_word(imem_addr);
      end else begin
        ack_busy <= 1'b1;
        ack_cnt  <= ack_delay - 1;
      end
    end else if (ack_busy) begin
      if (ack_cnt == 1) begin
        imem_ack   <= 1'b1;
        imem_instr <= read_word(imem_addr);         // address held by fetch
        ack_busy   <= 1'b0;
      end else begin
        ack_cnt <= ack_cnt - 1;
      end
    end
  end

  task automatic read_cases();
    int              fd;
    int              n;
    logic [8*128-1:0] line;
    logic [8*16-1:0]  tag;
    logic [8*32-1:0]  name;
    logic [31:0]      f1, f2, f3, f4;
    int               n_prog, n_exp;
    n_tests = 0;
    n_prog  = 0;
    n_exp   = 0;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the case file %0s", CASE_FILE);
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s", tag);
        if (n == 1 && tag == "test") begin
          n = $sscanf(line, "%s %s", tag, name);
          test_name[n_tests]  = name;
          prog_first[n_tests] = n_prog;
          exp_first[n_tests]  = n_exp;
          n_tests++;
        end else if (n == 1 && tag == "imem") begin
          n = $sscanf(line, "%s %h %h", tag, f1, f2);
          prog_addr[n_prog] = f1;
          prog_word[n_prog] = f2;
          n_prog++;
        end else if (n == 1 && tag == "ret") begin
          n = $sscanf(line, "%s %h %h %h %h", tag, f1, f2, f3, f4);
          exp_pc[n_exp]   = f1;
          exp_we[n_exp]   = f2[0];
          exp_rd[n_exp]   = f3[4:0];
          exp_data[n_exp] = f4;
          n_exp++;
        end
      end
    end
    prog_first[n_tests] = n_prog;
    exp_first[n_tests]  = n_exp;
    $fclose(fd);
  endtask

  task automatic run_test(input int t, input logic use_random);
    int k;
    int cycles;
    int fails;
    logic timed_out;
    fails     = 0;
    timed_out = 1'b0;
    for (k = 0; k < MEM_WORDS; k++) begin
      mem[k] = fill_word(k * 4);
    end
    for (k = prog_first[t]; k < prog_first[t+1]; k++) begin
      mem[prog_addr[k][7:2]] = prog_word[k];
    end
    @(posedge clk);
    rst_n       <= 1'b0;
    random_acks <= use_random;
    // strobe and retire stay quiet through reset
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      if (imem_stb !== 1'b0 || retire_valid !== 1'b0) begin
        $display("strobe or retire active during reset in test %0s", test_name[t]);
        fails++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (imem_stb !== 1'b1 && cycles < STB_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (imem_stb !== 1'b1) begin
      $display("no instruction request after reset in test %0s", test_name[t]);
      fails++;
    end else if (imem_addr !== RESET_PC) begin
      $display("error o_imem_addr expected %08h actual %08h", RESET_PC, imem_addr);
      fails++;
    end
    ////////////////////////////////////////////////////////////////////
    // retire trace in program order
    ////////////////////////////////////////////////////////////////////
    for (k = exp_first[t]; k < exp_first[t+1] && !timed_out; k++) begin
      cycles = 0;
      @(negedge clk);
      while (retire_valid !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (retire_valid !== 1'b1) begin
        $display("no retire within %0d cycles, waiting for pc %08h", RETIRE_TIMEOUT, exp_pc[k]);
        fails++;
        timed_out = 1'b1;
      end else begin
        if (retire_pc !== exp_pc[k]) begin
          $display("error o_retire_pc expected %08h actual %08h", exp_pc[k], retire_pc);
          fails++;
        end
        if (retire_we !== exp_we[k]) begin
          $display("error o_retire_we expected %h actual %h at pc %08h",
                   exp_we[k], retire_we, exp_pc[k]);
          fails++;
        end
        if (exp_we[k] && retire_rd_addr !== exp_rd[k]) begin
          $display("error o_retire_rd_addr expected %02h actual %02h at pc %08h",
                   exp_rd[k], retire_rd_addr, exp_pc[k]);
          fails++;
        end
        if (exp_we[k] && retire_rd_data !== exp_data[k]) begin
          $display("error o_retire_rd_data expected %08h actual %08h at pc %08h",
                   exp_data[k], retire_rd_data, exp_pc[k]);
          fails++;
        end
      end
    end
    errors += fails;
    if (fails == 0) begin
      runs_ok++;
    end else begin
      runs_bad++;
    end
    $display("test %0s, %0s acks: %0s, %0d mismatches", test_name[t],
             use_random ? "random" : "one-cycle", (fails == 0) ? "ok" : "FAILED", fails);
  endtask

  initial begin
    int t;
    errors   = 0;
    runs_ok  = 0;
    runs_bad = 0;
    read_cases();
    for (t = 0; t < n_tests; t++) begin
      run_test(t, 1'b0);
      run_test(t, 1'b1);
    end
    $display("%0d runs, %0d ok, %0d failed, %0d errors", runs_ok + runs_bad, runs_ok,
             runs_bad, errors);
    if (errors == 0 && n_tests > 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verification/core_cases.txt ====
# test <name>, then imem <addr> <word>, then ret <pc> <we> <rd> <rd value>, all hex
# rd and rd value are checked only where we is 1
test alu
imem 00000000 12300093
imem 00000004 ffb00113
imem 00000008 002081b3
imem 0000000c 40208233
imem 00000010 00409293
imem 00000014 00112333
imem 00000018 001133b3
imem 0000001c 0020c433
imem 00000020 00415493
imem 00000024 40115513
imem 00000028 0020e5b3
imem 0000002c 0f00f613
imem 00000030 123456b7
imem 00000034 00001717
imem 00000038 00708013
imem 0000003c 001007b3
ret 00000000 1 01 00000123
ret 00000004 1 02 fffffffb
ret 00000008 1 03 0000011e
ret 0000000c 1 04 00000128
ret 00000010 1 05 00001230
ret 00000014 1 06 00000001
ret 00000018 1 07 00000000
ret 0000001c 1 08 fffffed8
ret 00000020 1 09 0fffffff
ret 00000024 1 0a fffffffd
ret 00000028 1 0b fffffffb
ret 0000002c 1 0c 00000020
ret 00000030 1 0d 12345000
ret 00000034 1 0e 00001034
ret 00000038 1 00 0000012a
ret 0000003c 1 0f 00000123
test branch
imem 00000000 00100093
imem 00000004 fff00113
imem 00000008 00108463
imem 00000010 00208463
imem 00000014 00209463
imem 0000001c 00109463
imem 00000020 00114463
imem 00000028 0020c463
imem 0000002c 0020d463
imem 00000034 00115463
imem 00000038 0020e463
imem 00000040 00116463
imem 00000044 00117463
imem 0000004c 0020f463
imem 00000050 008002ef
imem 00000058 01128367
imem 00000064 00130393
ret 00000000 1 01 00000001
ret 00000004 1 02 ffffffff
ret 00000008 0 00 00000000
ret 00000010 0 00 00000000
ret 00000014 0 00 00000000
ret 0000001c 0 00 00000000
ret 00000020 0 00 00000000
ret 00000028 0 00 00000000
ret 0000002c 0 00 00000000
ret 00000034 0 00 00000000
ret 00000038 0 00 00000000
ret 00000040 0 00 00000000
ret 00000044 0 00 00000000
ret 0000004c 0 00 00000000
ret 00000050 1 05 00000054
ret 00000058 1 06 0000005c
ret 00000064 1 07 0000005d

// ==== tb.f ====
design/rv32i_pkg.sv
design/rv32i_stage_if.sv
design/rv32i_fetch.sv
design/rv32i_decode.sv
design/rv32i_regfile.sv
design/rv32i_execute.sv
design/rv32i_core.sv
verification/tb_core.sv
